/* hw/isa_pkg.sv */
package isa_pkg;

    localparam int INST_W     = 32;
    localparam int OPCODE_W   = 7;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 5;
    localparam int IMM_W      = 32;
    localparam int FUNCT3_W   = 3;

    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int ALT_BIT    = 30;

    typedef logic [INST_W-1:0]     inst_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [SHAMT_W-1:0]    shamt_t;
    typedef logic [IMM_W-1:0]      imm_t;
    typedef logic [OPCODE_W-1:0]   opcode_t;

    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_SYSTEM = 7'b1110011;

    // Table lengths of the opcode, format and funct decoders
    localparam int NR_OPCODE = 9;
    localparam int NR_FORMAT = 6;
    localparam int NR_BRANCH = 6;
    localparam int NR_LOAD   = 5;
    localparam int NR_STORE  = 3;
    localparam int NR_OP_IMM = 9;
    localparam int NR_OP_REG = 10;
    localparam int NR_SYSTEM = 2;

    typedef enum logic [5:0] {
        INST_INV, INST_AUIPC, INST_JAL, INST_JALR,
        INST_BEQ, INST_BNE, INST_BLT, INST_BGE, INST_BLTU, INST_BGEU,
        INST_LB, INST_LH, INST_LW, INST_LBU, INST_LHU,
        INST_SB, INST_SH, INST_SW,
        INST_ADDI, INST_SLTI, INST_SLTIU, INST_XORI, INST_ORI, INST_ANDI,
        INST_SLLI, INST_SRLI, INST_SRAI,
        INST_ADD, INST_SUB, INST_SLL, INST_SLT, INST_SLTU,
        INST_XOR, INST_OR, INST_AND, INST_SRL, INST_SRA,
        INST_ECALL, INST_EBREAK
    } inst_num_t;

    // N marks a word that has no valid format
    typedef enum logic [2:0] {R, I, S, B, U, J, N} inst_type_t;

endpackage

/* hw/bus_pkg.sv */
package bus_pkg;

    localparam int WB_DATA_W = 32;
    localparam int WB_ADDR_W = 32;

    typedef logic [WB_DATA_W-1:0] word_t;
    typedef logic [WB_ADDR_W-1:0] addr_t;

    // Fetch starts here after reset
    localparam addr_t RESET_PC = 32'h0000_0000;

    // Byte distance between consecutive instruction words
    localparam addr_t PC_STEP = 32'd4;

endpackage

/* hw/key_mux.sv */
`timescale 1ns/1ps

module key_mux #(
    parameter type data_t  = logic,
    parameter int  NR_KEY  = 2,
    parameter int  KEY_LEN = 1
) (
    input  logic [KEY_LEN-1:0] key,
    input  data_t              default_out,
    input  logic [KEY_LEN-1:0] key_table [NR_KEY],
    input  data_t              data_table [NR_KEY],
    output data_t              out
);

    logic [NR_KEY-1:0] hits;

    always_comb begin
        out  = default_out;
        hits = '0;
        for (int i = 0; i < NR_KEY; i++) begin
            if (key == key_table[i]) begin
                hits[i] = 1'b1;
                out     = data_table[i];
            end
        end
    end

    // A key table with duplicate entries would make the output order dependent
    always_comb begin
        assert ($onehot0(hits))
            else $error("key_mux: %0d entries match key %h", $countones(hits), key);
    end

endmodule

/* hw/idu_funct.sv */
`timescale 1ns/1ps

module idu_funct (
    input  isa_pkg::inst_t     inst,
    output isa_pkg::inst_num_t beq_num,
    output isa_pkg::inst_num_t lb_num,
    output isa_pkg::inst_num_t sb_num,
    output isa_pkg::inst_num_t addi_num,
    output isa_pkg::inst_num_t add_num,
    output isa_pkg::inst_num_t ebreak_num
);

    logic [isa_pkg::FUNCT3_W-1:0]    funct3;
    logic [isa_pkg::FUNCT3_W:0]      imm_key;
    logic [isa_pkg::FUNCT3_W:0]      reg_key;
    logic [11+isa_pkg::FUNCT3_W:0]   sys_key;

    logic [isa_pkg::FUNCT3_W-1:0]    br_keys  [isa_pkg::NR_BRANCH];
    isa_pkg::inst_num_t              br_nums  [isa_pkg::NR_BRANCH];
    logic [isa_pkg::FUNCT3_W-1:0]    ld_keys  [isa_pkg::NR_LOAD];
    isa_pkg::inst_num_t              ld_nums  [isa_pkg::NR_LOAD];
    logic [isa_pkg::FUNCT3_W-1:0]    st_keys  [isa_pkg::NR_STORE];
    isa_pkg::inst_num_t              st_nums  [isa_pkg::NR_STORE];
    logic [isa_pkg::FUNCT3_W:0]      imm_keys [isa_pkg::NR_OP_IMM];
    isa_pkg::inst_num_t              imm_nums [isa_pkg::NR_OP_IMM];
    logic [isa_pkg::FUNCT3_W:0]      reg_keys [isa_pkg::NR_OP_REG];
    isa_pkg::inst_num_t              reg_nums [isa_pkg::NR_OP_REG];
    logic [11+isa_pkg::FUNCT3_W:0]   sys_keys [isa_pkg::NR_SYSTEM];
    isa_pkg::inst_num_t              sys_nums [isa_pkg::NR_SYSTEM];

    assign funct3  = inst[isa_pkg::FUNCT3_LSB +: isa_pkg::FUNCT3_W];
    // Bit 30 belongs to the immediate except for shifts, where it selects srai
    assign imm_key = {inst[isa_pkg::ALT_BIT] & (funct3[1:0] == 2'b01), funct3};
    assign reg_key = {inst[isa_pkg::ALT_BIT], funct3};
    // CSR accesses share the opcode but never have funct3 zero
    assign sys_key = {inst[31:20], funct3};

    assign br_keys = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    assign br_nums = '{isa_pkg::INST_BEQ, isa_pkg::INST_BNE, isa_pkg::INST_BLT,
                       isa_pkg::INST_BGE, isa_pkg::INST_BLTU, isa_pkg::INST_BGEU};

    assign ld_keys = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
    assign ld_nums = '{isa_pkg::INST_LB, isa_pkg::INST_LH, isa_pkg::INST_LW,
                       isa_pkg::INST_LBU, isa_pkg::INST_LHU};

    assign st_keys = '{3'b000, 3'b001, 3'b010};
    assign st_nums = '{isa_pkg::INST_SB, isa_pkg::INST_SH, isa_pkg::INST_SW};

    assign imm_keys = '{4'b0000, 4'b0010, 4'b0011, 4'b0100, 4'b0110,
                        4'b0111, 4'b0001, 4'b0101, 4'b1101};
    assign imm_nums = '{isa_pkg::INST_ADDI, isa_pkg::INST_SLTI, isa_pkg::INST_SLTIU,
                        isa_pkg::INST_XORI, isa_pkg::INST_ORI, isa_pkg::INST_ANDI,
                        isa_pkg::INST_SLLI, isa_pkg::INST_SRLI, isa_pkg::INST_SRAI};

    assign reg_keys = '{4'b0000, 4'b1000, 4'b0001, 4'b0010, 4'b0011,
                        4'b0100, 4'b0110, 4'b0111, 4'b0101, 4'b1101};
    assign reg_nums = '{isa_pkg::INST_ADD, isa_pkg::INST_SUB, isa_pkg::INST_SLL,
                        isa_pkg::INST_SLT, isa_pkg::INST_SLTU, isa_pkg::INST_XOR,
                        isa_pkg::INST_OR, isa_pkg::INST_AND, isa_pkg::INST_SRL,
                        isa_pkg::INST_SRA};

    assign sys_keys = '{{12'h000, 3'b000}, {12'h001, 3'b000}};
    assign sys_nums = '{isa_pkg::INST_ECALL, isa_pkg::INST_EBREAK};

    key_mux #(.data_t(isa_pkg::inst_num_t), .NR_KEY(isa_pkg::NR_BRANCH),
              .KEY_LEN(isa_pkg::FUNCT3_W)) u_branch (
        .key(funct3), .default_out(isa_pkg::INST_INV),
        .key_table(br_keys), .data_table(br_nums), .out(beq_num)
    );

    key_mux #(.data_t(isa_pkg::inst_num_t), .NR_KEY(isa_pkg::NR_LOAD),
              .KEY_LEN(isa_pkg::FUNCT3_W)) u_load (
        .key(funct3), .default_out(isa_pkg::INST_INV),
        .key_table(ld_keys), .data_table(ld_nums), .out(lb_num)
    );

    key_mux #(.data_t(isa_pkg::inst_num_t), .NR_KEY(isa_pkg::NR_STORE),
              .KEY_LEN(isa_pkg::FUNCT3_W)) u_store (
        .key(funct3), .default_out(isa_pkg::INST_INV),
        .key_table(st_keys), .data_table(st_nums), .out(sb_num)
    );

    key_mux #(.data_t(isa_pkg::inst_num_t), .NR_KEY(isa_pkg::NR_OP_IMM),
              .KEY_LEN(isa_pkg::FUNCT3_W + 1)) u_op_imm (
        .key(imm_key), .default_out(isa_pkg::INST_INV),
        .key_table(imm_keys), .data_table(imm_nums), .out(addi_num)
    );

    key_mux #(.data_t(isa_pkg::inst_num_t), .NR_KEY(isa_pkg::NR_OP_REG),
              .KEY_LEN(isa_pkg::FUNCT3_W + 1)) u_op_reg (
        .key(reg_key), .default_out(isa_pkg::INST_INV),
        .key_table(reg_keys), .data_table(reg_nums), .out(add_num)
    );

    key_mux #(.data_t(isa_pkg::inst_num_t), .NR_KEY(isa_pkg::NR_SYSTEM),
              .KEY_LEN(12 + isa_pkg::FUNCT3_W)) u_system (
        .key(sys_key), .default_out(isa_pkg::INST_INV),
        .key_table(sys_keys), .data_table(sys_nums), .out(ebreak_num)
    );

endmodule

/* hw/idu_opcode.sv */
`timescale 1ns/1ps

module idu_opcode (
    input  logic                clk,
    input  logic                reset,
    input  isa_pkg::inst_t      inst,
    input  isa_pkg::inst_num_t  beq_num,
    input  isa_pkg::inst_num_t  lb_num,
    input  isa_pkg::inst_num_t  sb_num,
    input  isa_pkg::inst_num_t  addi_num,
    input  isa_pkg::inst_num_t  add_num,
    input  isa_pkg::inst_num_t  ebreak_num,
    output isa_pkg::inst_num_t  inst_num,
    output isa_pkg::inst_type_t inst_type,
    output isa_pkg::reg_addr_t  rd,
    output isa_pkg::reg_addr_t  rs1,
    output isa_pkg::reg_addr_t  rs2,
    output isa_pkg::imm_t       imm,
    output isa_pkg::shamt_t     shamt
);

    isa_pkg::opcode_t    opcode;
    isa_pkg::opcode_t    op_keys  [isa_pkg::NR_OPCODE];
    isa_pkg::inst_num_t  op_nums  [isa_pkg::NR_OPCODE];
    isa_pkg::inst_type_t op_types [isa_pkg::NR_OPCODE];
    isa_pkg::inst_type_t raw_type;
    logic [2:0]          fmt_keys [isa_pkg::NR_FORMAT];
    isa_pkg::imm_t       fmt_imms [isa_pkg::NR_FORMAT];

    assign opcode = inst[isa_pkg::OPCODE_W-1:0];

    assign op_keys  = '{isa_pkg::OP_AUIPC, isa_pkg::OP_JAL, isa_pkg::OP_JALR,
                        isa_pkg::OP_BRANCH, isa_pkg::OP_LOAD, isa_pkg::OP_STORE,
                        isa_pkg::OP_IMM, isa_pkg::OP_REG, isa_pkg::OP_SYSTEM};
    assign op_nums  = '{isa_pkg::INST_AUIPC, isa_pkg::INST_JAL, isa_pkg::INST_JALR,
                        beq_num, lb_num, sb_num, addi_num, add_num, ebreak_num};
    assign op_types = '{isa_pkg::U, isa_pkg::J, isa_pkg::I, isa_pkg::B, isa_pkg::I,
                        isa_pkg::S, isa_pkg::I, isa_pkg::R, isa_pkg::I};

    key_mux #(.data_t(isa_pkg::inst_num_t), .NR_KEY(isa_pkg::NR_OPCODE),
              .KEY_LEN(isa_pkg::OPCODE_W)) u_num (
        .key(opcode), .default_out(isa_pkg::INST_INV),
        .key_table(op_keys), .data_table(op_nums), .out(inst_num)
    );

    key_mux #(.data_t(isa_pkg::inst_type_t), .NR_KEY(isa_pkg::NR_OPCODE),
              .KEY_LEN(isa_pkg::OPCODE_W)) u_type (
        .key(opcode), .default_out(isa_pkg::N),
        .key_table(op_keys), .data_table(op_types), .out(raw_type)
    );

    // A known opcode with an undefined funct field still has no format
    assign inst_type = (inst_num == isa_pkg::INST_INV) ? isa_pkg::N : raw_type;

    assign rd    = inst[isa_pkg::RD_LSB +: isa_pkg::REG_ADDR_W];
    assign rs1   = inst[isa_pkg::RS1_LSB +: isa_pkg::REG_ADDR_W];
    assign rs2   = inst[isa_pkg::RS2_LSB +: isa_pkg::REG_ADDR_W];
    assign shamt = inst[isa_pkg::RS2_LSB +: isa_pkg::SHAMT_W];

    assign fmt_keys = '{isa_pkg::R, isa_pkg::I, isa_pkg::S,
                        isa_pkg::B, isa_pkg::U, isa_pkg::J};
    assign fmt_imms = '{
        '0,
        {{20{inst[31]}}, inst[31:20]},
        {{20{inst[31]}}, inst[31:25], inst[11:7]},
        {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0},
        {inst[31:12], 12'b0},
        {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}
    };

    key_mux #(.data_t(isa_pkg::imm_t), .NR_KEY(isa_pkg::NR_FORMAT),
              .KEY_LEN(3)) u_imm (
        .key(inst_type), .default_out('0),
        .key_table(fmt_keys), .data_table(fmt_imms), .out(imm)
    );

    // Branch and jump targets are always halfword aligned
    assert property (@(posedge clk) disable iff (reset)
        (inst_type inside {isa_pkg::B, isa_pkg::J}) |-> !imm[0]);

    assert property (@(posedge clk) disable iff (reset)
        (inst_type == isa_pkg::N) == (inst_num == isa_pkg::INST_INV));

endmodule

/* hw/ifu_fetch.sv */
`timescale 1ns/1ps

module ifu_fetch (
    input  logic               clk,
    input  logic               reset,
    output logic               wb_cyc,
    output logic               wb_stb,
    output bus_pkg::addr_t     wb_adr,
    input  bus_pkg::word_t     wb_dat,
    input  logic               wb_ack,
    output isa_pkg::inst_t     inst,
    output bus_pkg::addr_t     pc,
    output logic               dec_valid,
    input  logic               dec_ready,
    input  isa_pkg::inst_num_t inst_num,
    output logic               halted
);

    logic           cyc_q;
    logic           valid_q;
    logic           halted_q;
    bus_pkg::addr_t pc_q;
    isa_pkg::inst_t inst_q;
    bus_pkg::addr_t inst_pc_q;

    logic ack;
    logic take;
    logic ebreak_out;
    logic start;

    assign ack        = cyc_q && wb_ack;
    assign take       = valid_q && dec_ready;
    assign ebreak_out = take && (inst_num == isa_pkg::INST_EBREAK);

    // A read starts once the buffer is empty or drains in this cycle
    assign start = !cyc_q && !halted_q && !ebreak_out && (!valid_q || take);

    always_ff @(posedge clk) begin
        if (reset) begin
            cyc_q    <= 1'b0;
            valid_q  <= 1'b0;
            halted_q <= 1'b0;
            pc_q     <= bus_pkg::RESET_PC;
        end else begin
            if (start) begin
                cyc_q <= 1'b1;
            end else if (ack) begin
                cyc_q <= 1'b0;
            end

            if (ack) begin
                valid_q <= 1'b1;
                pc_q    <= pc_q + bus_pkg::PC_STEP;
            end else if (take) begin
                valid_q <= 1'b0;
            end

            if (ebreak_out) begin
                halted_q <= 1'b1;
            end
        end
    end

    // The buffered word keeps the address it was fetched from
    always_ff @(posedge clk) begin
        if (ack) begin
            inst_q    <= wb_dat;
            inst_pc_q <= pc_q;
        end
    end

    assign wb_cyc    = cyc_q;
    assign wb_stb    = cyc_q;
    assign wb_adr    = pc_q;
    assign inst      = inst_q;
    assign pc        = inst_pc_q;
    assign dec_valid = valid_q;
    assign halted    = halted_q;

    assert property (@(posedge clk) disable iff (reset) wb_stb |-> wb_cyc);

    assert property (@(posedge clk) disable iff (reset)
        (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr)));

    assert property (@(posedge clk) disable iff (reset)
        (dec_valid && !dec_ready) |=> (dec_valid && $stable(inst) && $stable(pc)));

endmodule

/* hw/frontend_top.sv */
`timescale 1ns/1ps

module frontend_top (
    input  logic                clk,
    input  logic                reset,
    output logic                wb_cyc,
    output logic                wb_stb,
    output bus_pkg::addr_t      wb_adr,
    input  bus_pkg::word_t      wb_dat,
    input  logic                wb_ack,
    output logic                dec_valid,
    input  logic                dec_ready,
    output bus_pkg::addr_t      pc,
    output isa_pkg::inst_num_t  inst_num,
    output isa_pkg::inst_type_t inst_type,
    output isa_pkg::reg_addr_t  rd,
    output isa_pkg::reg_addr_t  rs1,
    output isa_pkg::reg_addr_t  rs2,
    output isa_pkg::imm_t       imm,
    output isa_pkg::shamt_t     shamt,
    output logic                halted
);

    isa_pkg::inst_t     inst;
    isa_pkg::inst_num_t beq_num;
    isa_pkg::inst_num_t lb_num;
    isa_pkg::inst_num_t sb_num;
    isa_pkg::inst_num_t addi_num;
    isa_pkg::inst_num_t add_num;
    isa_pkg::inst_num_t ebreak_num;

    ifu_fetch u_fetch (
        .clk(clk), .reset(reset),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
        .wb_dat(wb_dat), .wb_ack(wb_ack),
        .inst(inst), .pc(pc), .dec_valid(dec_valid), .dec_ready(dec_ready),
        .inst_num(inst_num), .halted(halted)
    );

    idu_funct u_funct (
        .inst(inst),
        .beq_num(beq_num), .lb_num(lb_num), .sb_num(sb_num),
        .addi_num(addi_num), .add_num(add_num), .ebreak_num(ebreak_num)
    );

    idu_opcode u_opcode (
        .clk(clk), .reset(reset), .inst(inst),
        .beq_num(beq_num), .lb_num(lb_num), .sb_num(sb_num),
        .addi_num(addi_num), .add_num(add_num), .ebreak_num(ebreak_num),
        .inst_num(inst_num), .inst_type(inst_type),
        .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm), .shamt(shamt)
    );

endmodule

/* tb/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release lands just after an edge, like the rest of the stimulus
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

/* tb/tb_frontend.sv */
`timescale 1ns/1ps

module tb_frontend;

    localparam int NR_TRANSFERS = 201;
    localparam int EBREAK_INDEX = 200;
    localparam int QUIET_CYCLES = 50;
    localparam int TIMEOUT      = 64 + NR_TRANSFERS * 12;

    // Reference lookups indexed by funct3, or by {bit 30, funct3} for the ALU groups
    localparam isa_pkg::inst_num_t BRANCH_OPS [8] = '{
        isa_pkg::INST_BEQ, isa_pkg::INST_BNE, isa_pkg::INST_INV, isa_pkg::INST_INV,
        isa_pkg::INST_BLT, isa_pkg::INST_BGE, isa_pkg::INST_BLTU, isa_pkg::INST_BGEU};
    localparam isa_pkg::inst_num_t LOAD_OPS [8] = '{
        isa_pkg::INST_LB, isa_pkg::INST_LH, isa_pkg::INST_LW, isa_pkg::INST_INV,
        isa_pkg::INST_LBU, isa_pkg::INST_LHU, isa_pkg::INST_INV, isa_pkg::INST_INV};
    localparam isa_pkg::inst_num_t STORE_OPS [8] = '{
        isa_pkg::INST_SB, isa_pkg::INST_SH, isa_pkg::INST_SW, isa_pkg::INST_INV,
        isa_pkg::INST_INV, isa_pkg::INST_INV, isa_pkg::INST_INV, isa_pkg::INST_INV};
    // Bit 30 is part of the immediate except for the right shift
    localparam isa_pkg::inst_num_t IMM_OPS [16] = '{
        isa_pkg::INST_ADDI, isa_pkg::INST_SLLI, isa_pkg::INST_SLTI, isa_pkg::INST_SLTIU,
        isa_pkg::INST_XORI, isa_pkg::INST_SRLI, isa_pkg::INST_ORI, isa_pkg::INST_ANDI,
        isa_pkg::INST_ADDI, isa_pkg::INST_INV, isa_pkg::INST_SLTI, isa_pkg::INST_SLTIU,
        isa_pkg::INST_XORI, isa_pkg::INST_SRAI, isa_pkg::INST_ORI, isa_pkg::INST_ANDI};
    localparam isa_pkg::inst_num_t REG_OPS [16] = '{
        isa_pkg::INST_ADD, isa_pkg::INST_SLL, isa_pkg::INST_SLT, isa_pkg::INST_SLTU,
        isa_pkg::INST_XOR, isa_pkg::INST_SRL, isa_pkg::INST_OR, isa_pkg::INST_AND,
        isa_pkg::INST_SUB, isa_pkg::INST_INV, isa_pkg::INST_INV, isa_pkg::INST_INV,
        isa_pkg::INST_INV, isa_pkg::INST_SRA, isa_pkg::INST_INV, isa_pkg::INST_INV};

    logic                clk;
    logic                reset;
    logic                wb_cyc;
    logic                wb_stb;
    bus_pkg::addr_t      wb_adr;
    bus_pkg::word_t      wb_dat;
    logic                wb_ack;
    logic                dec_valid;
    logic                dec_ready;
    bus_pkg::addr_t      pc;
    isa_pkg::inst_num_t  inst_num;
    isa_pkg::inst_type_t inst_type;
    isa_pkg::reg_addr_t  rd;
    isa_pkg::reg_addr_t  rs1;
    isa_pkg::reg_addr_t  rs2;
    isa_pkg::imm_t       imm;
    isa_pkg::shamt_t     shamt;
    logic                halted;

    bus_pkg::word_t mem [256];
    logic [31:0]    rng_state;
    int             cycles;
    int             nr_requests;
    int             nr_transfers;
    int             wait_left;
    int             quiet;
    logic           busy;
    logic           stalled;
    logic           halt_due;
    bus_pkg::addr_t req_adr;
    bus_pkg::addr_t held_pc;

    tb_clock #(.PERIOD_NS(20), .RESET_CYCLES(5)) u_clock (.clk(clk), .reset(reset));

    frontend_top UUT (
        .clk(clk), .reset(reset),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr), .wb_dat(wb_dat), .wb_ack(wb_ack),
        .dec_valid(dec_valid), .dec_ready(dec_ready), .pc(pc),
        .inst_num(inst_num), .inst_type(inst_type),
        .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm), .shamt(shamt), .halted(halted)
    );

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic bus_pkg::word_t random_inst();
        logic [31:0]    r;
        logic [31:0]    sel;
        logic [2:0]     f3;
        logic [2:0]     br_f3;
        logic [2:0]     ld_f3;
        logic [2:0]     st_f3;
        logic [6:0]     f7;
        bus_pkg::word_t w;
        r     = next_random();
        sel   = next_random();
        f3    = r[14:12];
        br_f3 = (f3[2:1] == 2'b01) ? {1'b1, f3[1:0]} : f3;
        ld_f3 = 3'(sel[15:8] % 5);
        if (ld_f3 > 3'd2)
            ld_f3 = ld_f3 + 3'd1;
        st_f3 = 3'(sel[23:16] % 3);
        case (sel % 12)
            0: w = {r[31:7], isa_pkg::OP_AUIPC};
            1: w = {r[31:7], isa_pkg::OP_JAL};
            2: w = {r[31:15], 3'b000, r[11:7], isa_pkg::OP_JALR};
            3: w = {r[31:15], br_f3, r[11:7], isa_pkg::OP_BRANCH};
            4: w = {r[31:15], ld_f3, r[11:7], isa_pkg::OP_LOAD};
            5: w = {r[31:15], st_f3, r[11:7], isa_pkg::OP_STORE};
            6: begin
                f7 = (f3 == 3'b001) ? 7'b0 : (f3 == 3'b101) ? {1'b0, r[30], 5'b0} : r[31:25];
                w  = {f7, r[24:15], f3, r[11:7], isa_pkg::OP_IMM};
            end
            7: begin
                f7 = (f3 == 3'b000 || f3 == 3'b101) ? {1'b0, r[30], 5'b0} : 7'b0;
                w  = {f7, r[24:15], f3, r[11:7], isa_pkg::OP_REG};
            end
            8: w = 32'h0000_0073;
            9, 10: w = r;
            // lui, fence and CSR accesses are outside the decoded set
            default: begin
                case (sel[31:30])
                    2'b00: w = {r[31:7], 7'b0110111};
                    2'b01: w = {r[31:7], 7'b0001111};
                    default: w = {r[31:15], f3 | 3'b001, r[11:7], isa_pkg::OP_SYSTEM};
                endcase
            end
        endcase
        return w;
    endfunction

    function automatic isa_pkg::inst_num_t decode_num(input bus_pkg::word_t w);
        logic [2:0]         f3;
        isa_pkg::inst_num_t num;
        f3 = w[14:12];
        case (w[6:0])
            isa_pkg::OP_AUIPC:  num = isa_pkg::INST_AUIPC;
            isa_pkg::OP_JAL:    num = isa_pkg::INST_JAL;
            isa_pkg::OP_JALR:   num = isa_pkg::INST_JALR;
            isa_pkg::OP_BRANCH: num = BRANCH_OPS[f3];
            isa_pkg::OP_LOAD:   num = LOAD_OPS[f3];
            isa_pkg::OP_STORE:  num = STORE_OPS[f3];
            isa_pkg::OP_IMM:    num = IMM_OPS[{w[30], f3}];
            isa_pkg::OP_REG:    num = REG_OPS[{w[30], f3}];
            isa_pkg::OP_SYSTEM: begin
                num = isa_pkg::INST_INV;
                if (f3 == 3'b000 && w[31:20] == 12'h000)
                    num = isa_pkg::INST_ECALL;
                if (f3 == 3'b000 && w[31:20] == 12'h001)
                    num = isa_pkg::INST_EBREAK;
            end
            default:            num = isa_pkg::INST_INV;
        endcase
        return num;
    endfunction

    function automatic isa_pkg::inst_type_t format_of(input bus_pkg::word_t w);
        isa_pkg::inst_type_t t;
        case (w[6:0])
            isa_pkg::OP_AUIPC:  t = isa_pkg::U;
            isa_pkg::OP_JAL:    t = isa_pkg::J;
            isa_pkg::OP_BRANCH: t = isa_pkg::B;
            isa_pkg::OP_STORE:  t = isa_pkg::S;
            isa_pkg::OP_REG:    t = isa_pkg::R;
            default:            t = isa_pkg::I;
        endcase
        if (decode_num(w) == isa_pkg::INST_INV)
            t = isa_pkg::N;
        return t;
    endfunction

    function automatic isa_pkg::imm_t build_imm(input bus_pkg::word_t w,
                                                 input isa_pkg::inst_type_t t);
        isa_pkg::imm_t fill;
        fill = {32{w[31]}};
        case (t)
            isa_pkg::I: return (fill << 12) | 32'(w[31:20]);
            isa_pkg::S: return (fill << 12) | (32'(w[31:25]) << 5) | 32'(w[11:7]);
            isa_pkg::B: return (fill << 12) | (32'(w[7]) << 11) | (32'(w[30:25]) << 5)
                               | (32'(w[11:8]) << 1);
            isa_pkg::U: return w & 32'hffff_f000;
            isa_pkg::J: return (fill << 20) | (32'(w[19:12]) << 12) | (32'(w[20]) << 11)
                               | (32'(w[30:21]) << 1);
            default:    return '0;
        endcase
    endfunction

    task automatic stop_on_error(string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_num(string what, isa_pkg::inst_num_t got, isa_pkg::inst_num_t exp);
        if (got !== exp)
            stop_on_error($sformatf("ERROR at %0t: %s is %s, expected %s",
                                    $time, what, got.name(), exp.name()));
    endtask

    task automatic check_type(string what, isa_pkg::inst_type_t got,
                              isa_pkg::inst_type_t exp);
        if (got !== exp)
            stop_on_error($sformatf("ERROR at %0t: %s is %s, expected %s",
                                    $time, what, got.name(), exp.name()));
    endtask

    task automatic check_word(string what, bus_pkg::word_t got, bus_pkg::word_t exp);
        if (got !== exp)
            stop_on_error($sformatf("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_reg(string what, isa_pkg::reg_addr_t got, isa_pkg::reg_addr_t exp);
        if (got !== exp)
            stop_on_error($sformatf("ERROR at %0t: %s is %0d, expected %0d",
                                    $time, what, got, exp));
    endtask

    // Slave side with 0 to 3 wait states, plus the Wishbone protocol monitor
    task automatic serve_bus();
        if (wb_stb !== wb_cyc)
            stop_on_error("wb_stb and wb_cyc disagree");
        if (wb_ack) begin
            wb_ack = 1'b0;
            if (wb_cyc)
                stop_on_error("wb_cyc stayed high after the acknowledge");
            if (!dec_valid)
                stop_on_error("dec_valid did not rise after the acknowledge");
        end else if (wb_cyc) begin
            if (!busy) begin
                if (dec_valid)
                    stop_on_error("A new bus request started while the buffer was full");
                check_word("request address", wb_adr, bus_pkg::RESET_PC + 32'(4 * nr_requests));
                busy        = 1'b1;
                req_adr     = wb_adr;
                wait_left   = int'(next_random() % 4);
                nr_requests = nr_requests + 1;
            end
            check_word("wb_adr while waiting", wb_adr, req_adr);
            if (wait_left == 0) begin
                wb_ack = 1'b1;
                wb_dat = mem[wb_adr[9:2]];
                busy   = 1'b0;
            end else begin
                wait_left = wait_left - 1;
            end
        end
    endtask

    task automatic check_transfer();
        bus_pkg::word_t      w;
        isa_pkg::inst_type_t t;
        if (nr_transfers > EBREAK_INDEX)
            stop_on_error("An instruction transferred after the ebreak");
        w = mem[nr_transfers];
        t = format_of(w);
        check_word("pc", pc, bus_pkg::RESET_PC + 32'(4 * nr_transfers));
        check_num("inst_num", inst_num, decode_num(w));
        check_type("inst_type", inst_type, t);
        check_reg("rd", rd, w[11:7]);
        check_reg("rs1", rs1, w[19:15]);
        check_reg("rs2", rs2, w[24:20]);
        check_reg("shamt", shamt, w[24:20]);
        check_word("imm", imm, build_imm(w, t));
        halt_due     = (decode_num(w) == isa_pkg::INST_EBREAK);
        nr_transfers = nr_transfers + 1;
    endtask

    task automatic handshake();
        if (stalled && (!dec_valid || pc !== held_pc))
            stop_on_error("The buffered instruction changed while the consumer stalled");
        dec_ready = (next_random() % 4) != 0;
        stalled   = dec_valid && !dec_ready;
        held_pc   = pc;
        if (dec_valid && dec_ready)
            check_transfer();
    endtask

    task automatic watch_halt();
        if (halt_due) begin
            if (!halted)
                stop_on_error("halted did not rise after the ebreak transferred");
            if (wb_cyc)
                stop_on_error("A bus cycle started after the fetch unit halted");
            quiet = quiet + 1;
        end else if (halted) begin
            stop_on_error("halted rose before the ebreak transferred");
        end
    endtask

    initial begin
        wb_dat       = '0;
        wb_ack       = 1'b0;
        dec_ready    = 1'b0;
        rng_state    = 32'h4bb7_8551;
        cycles       = 0;
        nr_requests  = 0;
        nr_transfers = 0;
        wait_left    = 0;
        quiet        = 0;
        busy         = 1'b0;
        stalled      = 1'b0;
        halt_due     = 1'b0;
        req_adr      = '0;
        held_pc      = '0;
        for (int i = 0; i < 256; i++) begin
            do begin
                mem[i] = random_inst();
            end while (decode_num(mem[i]) == isa_pkg::INST_EBREAK);
        end
        mem[EBREAK_INDEX] = 32'h0010_0073;

        @(posedge clk);
        #1;
        if (wb_cyc || wb_stb || dec_valid || halted)
            stop_on_error("Bus, buffer or halt state not cleared by reset");
        check_word("wb_adr in reset", wb_adr, bus_pkg::RESET_PC);

        @(negedge reset);
        while (quiet < QUIET_CYCLES) begin
            @(posedge clk);
            #1;
            cycles = cycles + 1;
            if (cycles > TIMEOUT)
                stop_on_error($sformatf("Timeout after %0d cycles with %0d of %0d transfers",
                                        cycles, nr_transfers, NR_TRANSFERS));
            serve_bus();
            watch_halt();
            handshake();
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* vlog.f */
hw/isa_pkg.sv
hw/bus_pkg.sv
hw/key_mux.sv
hw/idu_funct.sv
hw/idu_opcode.sv
hw/ifu_fetch.sv
hw/frontend_top.sv
tb/tb_clock.sv
tb/tb_frontend.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it; a failing run exits non-zero
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_frontend -f vlog.f -o tb_frontend
./obj_dir/tb_frontend
